// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sifhTb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/sifhFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhFsm (
    input  logic                         clk,
    input  logic                         arstN,
    // code input
    input  logic                         dataValid,
    output logic                         dataReady,
    input  sifhPkg::tdcCode_t            data,
    // per-pixel result
    output logic                         peakValid,
    output logic [sifhPkg::PIX_W-1:0]    peakPixel,
    output logic [sifhPkg::Nb-1:0]       peakBin,
    output logic [sifhPkg::peakMax-1:0]  peakCount
);
    import sifhPkg::*;

    logic [1:0] state;
    logic [1:0] stateNext;
    logic [ACQ_W-1:0] acqCnt;
    logic drainCnt;
    logic [PIX_W-1:0] pixel;

    logic accept;
    logic isPhoton;
    logic lastAcq;

    // pipeline, stage 1 waits for RAM data, stage 2 writes back
    logic s1Valid;
    logic [Nb-1:0] s1Bin;
    logic s2Valid;
    logic [Nb-1:0] s2Bin;
    logic [peakMax-1:0] s2Count;
    // write of the previous cycle, missed by a read-first RAM
    logic wrValidD;
    logic [Nb-1:0] wrBinD;
    logic [peakMax-1:0] wrCountD;
    logic [peakMax-1:0] fwdCount;
    logic [peakMax-1:0] incCount;

    // RAM ports after arbitration
    logic [Nb-1:0] raddr;
    logic rEnable;
    logic [Nb-1:0] waddr;
    logic wEnable;
    logic [peakMax-1:0] newCounts;
    logic [peakMax-1:0] counts;

    // peak finder side
    logic scanStart;
    logic [Nb-1:0] scanAddr;
    logic scanRead;
    logic [Nb-1:0] clrAddr;
    logic clrWrite;
    logic scanDone;

    assign accept = dataValid && dataReady;
    assign isPhoton = (data.raw != NO_PHOTON);
    assign lastAcq = accept && (acqCnt == ACQ_W'(ACQ_NUM - 1));
    // second drain cycle, first scan read follows
    assign scanStart = (state == ST_DRAIN) && drainCnt;

    always_comb begin
        stateNext = state;
        case (state)
            ST_ACQUIRE: if (lastAcq) stateNext = ST_DRAIN;
            ST_DRAIN:   if (drainCnt) stateNext = ST_SCAN;
            ST_SCAN:    if (scanDone) stateNext = ST_REPORT;
            ST_REPORT:  stateNext = ST_ACQUIRE;
            default:    stateNext = ST_ACQUIRE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ST_ACQUIRE;
            dataReady <= 1'b0;
            acqCnt <= '0;
            drainCnt <= 1'b0;
            pixel <= '0;
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            wrValidD <= 1'b0;
        end else begin
            state <= stateNext;
            // low from the edge of the last accept until after the report
            dataReady <= (stateNext == ST_ACQUIRE);
            if (accept) begin
                acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
            end
            drainCnt <= (state == ST_DRAIN) ? ~drainCnt : 1'b0;
            if (state == ST_REPORT) begin
                pixel <= (pixel == PIX_W'(PIXEL_NUM - 1)) ? '0 : pixel + 1'b1;
            end
            // no-photon codes take no RAM slot
            s1Valid <= accept && isPhoton;
            s2Valid <= s1Valid;
            wrValidD <= wEnable;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= data.fields.bin;
        s2Bin <= s1Bin;
        s2Count <= incCount;
        wrBinD <= waddr;
        wrCountD <= newCounts;
    end

    // newest pending value first, then the write the read missed
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            fwdCount = s2Count;
        end else if (wrValidD && (wrBinD == s1Bin)) begin
            fwdCount = wrCountD;
        end else begin
            fwdCount = counts;
        end
        // saturating increment
        incCount = (fwdCount == COUNT_MAX) ? fwdCount : fwdCount + 1'b1;
    end

    // peak finder owns both ports during the scan
    always_comb begin
        if (state == ST_SCAN) begin
            raddr = scanAddr;
            rEnable = scanRead;
            waddr = clrAddr;
            wEnable = clrWrite;
            newCounts = '0;
        end else begin
            raddr = data.fields.bin;
            rEnable = accept && isPhoton;
            waddr = s2Bin;
            wEnable = s2Valid;
            newCounts = s2Count;
        end
    end

    sifhHistRam u_sifhHistRam (
        .clk       (clk),
        .wEnable   (wEnable),
        .waddr     (waddr),
        .newCounts (newCounts),
        .rEnable   (rEnable),
        .raddr     (raddr),
        .counts    (counts)
    );

    sifhPeakFinder u_sifhPeakFinder (
        .clk       (clk),
        .arstN     (arstN),
        .scanStart (scanStart),
        .scanAddr  (scanAddr),
        .scanRead  (scanRead),
        .binCount  (counts),
        .clrAddr   (clrAddr),
        .clrWrite  (clrWrite),
        .scanDone  (scanDone),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    // finder holds its maximum through the report cycle
    assign peakValid = (state == ST_REPORT);
    assign peakPixel = pixel;

endmodule

`default_nettype wire

// ==== source/sifhHistRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhHistRam (
    input  logic                         clk,
    // port a, write only
    input  logic                         wEnable,
    input  logic [sifhPkg::Nb-1:0]       waddr,
    input  logic [sifhPkg::peakMax-1:0]  newCounts,
    // port b, registered read
    input  logic                         rEnable,
    input  logic [sifhPkg::Nb-1:0]       raddr,
    output logic [sifhPkg::peakMax-1:0]  counts
);
    import sifhPkg::*;

    // one count per bin
    logic [peakMax-1:0] mem [BIN_NUM];

    // empty histogram at power-up
    initial begin
        for (int i = 0; i < BIN_NUM; i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // read port, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== source/sifhPeakFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhPeakFinder (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         scanStart,
    // read side of the scan
    output logic [sifhPkg::Nb-1:0]       scanAddr,
    output logic                         scanRead,
    input  logic [sifhPkg::peakMax-1:0]  binCount,
    // clearing writes behind the reads
    output logic [sifhPkg::Nb-1:0]       clrAddr,
    output logic                         clrWrite,
    // result
    output logic                         scanDone,
    output logic [sifhPkg::Nb-1:0]       peakBin,
    output logic [sifhPkg::peakMax-1:0]  peakCount
);
    import sifhPkg::*;

    logic scanning;
    // read pipeline, stage 1 has the data, stage 2 clears
    logic rdValid1;
    logic rdValid2;
    logic [Nb-1:0] rdAddr1;
    logic [Nb-1:0] rdAddr2;
    // running maximum
    logic [Nb-1:0] maxBin;
    logic [peakMax-1:0] maxCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scanning <= 1'b0;
            scanAddr <= '0;
            rdValid1 <= 1'b0;
            rdValid2 <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            if (scanStart) begin
                scanning <= 1'b1;
                scanAddr <= '0;
            end else if (scanning) begin
                scanAddr <= scanAddr + 1'b1;
                // stop after the top bin
                if (scanAddr == '1) begin
                    scanning <= 1'b0;
                end
            end
            rdValid1 <= scanning;
            rdValid2 <= rdValid1;
            // one cycle after the compare of the top bin
            scanDone <= rdValid1 && (rdAddr1 == '1);
        end
    end

    always_ff @(posedge clk) begin
        rdAddr1 <= scanAddr;
        rdAddr2 <= rdAddr1;
        if (scanStart) begin
            maxBin <= '0;
            maxCount <= '0;
        end else if (rdValid1 && (binCount > maxCount)) begin
            // strict compare, ties keep the lower bin
            maxBin <= rdAddr1;
            maxCount <= binCount;
        end
    end

    assign scanRead = scanning;
    // bin is zeroed two cycles after its read
    assign clrAddr = rdAddr2;
    assign clrWrite = rdValid2;
    assign peakBin = maxBin;
    assign peakCount = maxCount;

endmodule

`default_nettype wire

// ==== source/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    // width of one TDC code
    localparam int Np = 10;
    // bin address width, 64 bins
    localparam int Nb = 6;
    localparam int BIN_NUM = 1 << Nb;
    // fine code below the bin field
    localparam int FINE_W = 4;
    // count width, counts stop at 255
    localparam int peakMax = 8;
    localparam logic [peakMax-1:0] COUNT_MAX = '1;

    // acquisitions per pixel, no-photon codes included
    localparam int ACQ_NUM = 40;
    localparam int ACQ_W = $clog2(ACQ_NUM);
    // pixels per frame and result entries
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W = 2;

    // all-ones code marks a missing photon
    localparam logic [Np-1:0] NO_PHOTON = '1;

    // controller states
    localparam logic [1:0] ST_ACQUIRE = 2'd0;
    localparam logic [1:0] ST_DRAIN = 2'd1;
    localparam logic [1:0] ST_SCAN = 2'd2;
    localparam logic [1:0] ST_REPORT = 2'd3;

    // wishbone sizes and status register
    localparam int WB_AW = 3;
    localparam int WB_DW = 16;
    localparam int FRAME_W = 8;
    localparam logic [WB_AW-1:0] STATUS_ADR = 3'd4;

    // raw word for the marker test, fields for the bin select
    typedef union packed {
        logic [Np-1:0] raw;
        struct packed {
            logic [Nb-1:0] bin;
            logic [FINE_W-1:0] fine;
        } fields;
    } tdcCode_t;

endpackage

`default_nettype wire

// ==== source/sifhTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  logic                         clk,
    input  logic                         arstN,
    // code input
    input  logic                         dataValid,
    output logic                         dataReady,
    input  sifhPkg::tdcCode_t            data,
    // wishbone classic
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [sifhPkg::WB_AW-1:0]    wbAdr,
    input  logic [sifhPkg::WB_DW-1:0]    wbDatW,
    output logic [sifhPkg::WB_DW-1:0]    wbDatR,
    output logic                         wbAck
);
    import sifhPkg::*;

    // result pulse and payload
    logic peakValid;
    logic [PIX_W-1:0] peakPixel;
    logic [Nb-1:0] peakBin;
    logic [peakMax-1:0] peakCount;

    sifhFsm u_sifhFsm (
        .clk       (clk),
        .arstN     (arstN),
        .dataValid (dataValid),
        .dataReady (dataReady),
        .data      (data),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    sifhWbSlave u_sifhWbSlave (
        .clk       (clk),
        .arstN     (arstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

endmodule

`default_nettype wire

// ==== source/sifhWbSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhWbSlave (
    input  logic                         clk,
    input  logic                         arstN,
    // wishbone classic
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [sifhPkg::WB_AW-1:0]    wbAdr,
    input  logic [sifhPkg::WB_DW-1:0]    wbDatW,
    output logic [sifhPkg::WB_DW-1:0]    wbDatR,
    output logic                         wbAck,
    // results from the controller
    input  logic                         peakValid,
    input  logic [sifhPkg::PIX_W-1:0]    peakPixel,
    input  logic [sifhPkg::Nb-1:0]       peakBin,
    input  logic [sifhPkg::peakMax-1:0]  peakCount
);
    import sifhPkg::*;

    // result bank, one entry per pixel
    logic [Nb-1:0] resBin [PIXEL_NUM];
    logic [peakMax-1:0] resCount [PIXEL_NUM];

    logic frameDone;
    logic [FRAME_W-1:0] frameCnt;
    logic wbReq;
    logic statusClr;
    logic lastPixel;

    // new request, not yet acked
    assign wbReq = wbCyc && wbStb && !wbAck;
    assign statusClr = wbReq && wbWe && (wbAdr == STATUS_ADR) && wbDatW[0];
    assign lastPixel = peakValid && (peakPixel == PIX_W'(PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck <= 1'b0;
            frameDone <= 1'b0;
            frameCnt <= '0;
        end else begin
            // one-cycle ack, gone when stb drops
            wbAck <= wbReq;
            // a finishing frame wins over a clear
            if (lastPixel) begin
                frameDone <= 1'b1;
                frameCnt <= frameCnt + 1'b1;
            end else if (statusClr) begin
                frameDone <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (peakValid) begin
            resBin[peakPixel] <= peakBin;
            resCount[peakPixel] <= peakCount;
        end
    end

    // read mux, unmapped addresses read zero
    always_comb begin
        wbDatR = '0;
        if (wbAdr == STATUS_ADR) begin
            wbDatR[WB_DW-1 -: FRAME_W] = frameCnt;
            wbDatR[0] = frameDone;
        end else if (wbAdr < WB_AW'(PIXEL_NUM)) begin
            wbDatR[peakMax +: Nb] = resBin[wbAdr[PIX_W-1:0]];
            wbDatR[peakMax-1:0] = resCount[wbAdr[PIX_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/sifhPkg.sv
source/sifhHistRam.sv
source/sifhPeakFinder.sv
source/sifhFsm.sv
source/sifhWbSlave.sv
source/sifhTop.sv
tb/sifhTop_assert.sv
tb/sifhTb.sv

// ==== tb/sifhTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    localparam int HALF_PERIOD = 5;
    localparam int DRIVE_DELAY = 1;
    localparam int FRAME_NUM = 3;
    // twice the budget of all pixels of all frames
    localparam int TIMEOUT_CYCLES = FRAME_NUM * PIXEL_NUM * (ACQ_NUM * 4 + 80) * 2;
    localparam logic [31:0] SEED = 32'h44675593;
    // pixel stimulus kinds
    localparam int KIND_RANDOM = 0;
    localparam int KIND_BURST = 1;
    localparam int KIND_EMPTY = 2;

    logic clk;
    logic arstN;
    logic dataValid;
    logic dataReady;
    tdcCode_t data;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [WB_AW-1:0] wbAdr;
    logic [WB_DW-1:0] wbDatW;
    logic [WB_DW-1:0] wbDatR;
    logic wbAck;

    // codes of the frame in flight per pixel
    tdcCode_t codeLog [PIXEL_NUM][ACQ_NUM];
    logic [31:0] rngState;
    int framesChecked = 0;
    int cycles = 0;
    int testsRun = 0;
    int testsFailed = 0;
    bit testOk = 1'b1;

    sifhTop u_sifhTop (
        .clk       (clk),
        .arstN     (arstN),
        .dataValid (dataValid),
        .dataReady (dataReady),
        .data      (data),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin : resetGen
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;
    end

    // one lcg step
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // burst and empty pixels move around between frames
    function automatic int pixelKind(input int f, input int p);
        if ((f == 0 && p == 1) || (f == 1 && p == 3) || (f == 2 && p == 2)) begin
            return KIND_BURST;
        end
        if ((f == 0 && p == 2) || (f == 2 && p == 0)) begin
            return KIND_EMPTY;
        end
        return KIND_RANDOM;
    endfunction

    function automatic string kindName(input int kind);
        if (kind == KIND_BURST) return "burst";
        if (kind == KIND_EMPTY) return "empty";
        return "random";
    endfunction

    function automatic tdcCode_t makeCode(input int kind, input logic [Nb-1:0] peak);
        tdcCode_t code;
        logic [31:0] r;
        r = nextRand();
        code.fields.fine = r[15:12];
        code.fields.bin = r[21:16];
        if (kind == KIND_EMPTY) begin
            code.raw = NO_PHOTON;
        end else if (kind == KIND_BURST) begin
            // low fine msb keeps the code off the marker
            code.fields.bin = peak;
            code.fields.fine = {1'b0, r[14:12]};
        end else if (r[31:29] < 3'd2) begin
            code.raw = NO_PHOTON;
        end else if (r[28]) begin
            code.fields.bin = peak;
        end
        return code;
    endfunction

    // expected {bin, count} of one pixel from its logged codes
    function automatic logic [Nb+peakMax-1:0] refPeak(input int pix);
        int hist [BIN_NUM];
        int bestBin;
        int bestCount;
        tdcCode_t code;
        for (int b = 0; b < BIN_NUM; b++) begin
            hist[b] = 0;
        end
        for (int i = 0; i < ACQ_NUM; i++) begin
            code = codeLog[pix][i];
            // markers are skipped and counts stop at 255
            if (code.raw != NO_PHOTON && hist[code.fields.bin] < (1 << peakMax) - 1) begin
                hist[code.fields.bin]++;
            end
        end
        bestBin = 0;
        bestCount = 0;
        // ties stay on the lower bin
        for (int b = 0; b < BIN_NUM; b++) begin
            if (hist[b] > bestCount) begin
                bestBin = b;
                bestCount = hist[b];
            end
        end
        return {Nb'(bestBin), peakMax'(bestCount)};
    endfunction

    // present one code until accepted with an optional idle gap first
    task automatic sendCode(input tdcCode_t code);
        logic [31:0] r;
        logic done;
        r = nextRand();
        if (r[31:30] == 2'b00) begin
            dataValid = 1'b0;
            repeat (int'(r[29:28]) + 1) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        dataValid = 1'b1;
        data = code;
        done = 1'b0;
        while (!done) begin
            // registered ready is steady at the falling edge
            @(negedge clk);
            done = dataReady;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        dataValid = 1'b0;
    endtask

    // single classic cycle with read data taken in the ack cycle
    task automatic busCycle(input logic we, input logic [WB_AW-1:0] adr,
                            input logic [WB_DW-1:0] wdata, output logic [WB_DW-1:0] rdata);
        @(posedge clk);
        #DRIVE_DELAY;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdata;
        @(negedge clk);
        while (!wbAck) begin
            @(negedge clk);
        end
        rdata = wbDatR;
        @(posedge clk);
        #DRIVE_DELAY;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic reportError(input string name, input logic [WB_DW-1:0] expected,
                               input logic [WB_DW-1:0] actual);
        $display("error %s: expected %h, actual %h", name, expected, actual);
        testOk = 1'b0;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testOk) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: FAILED", name);
        end
        testOk = 1'b1;
    endtask

    initial begin : stimulus
        logic [Nb-1:0] peak;
        logic [31:0] r;
        tdcCode_t code;
        int kind;
        rngState = SEED;
        dataValid = 1'b0;
        data = '0;
        wait (arstN === 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;
        for (int f = 0; f < FRAME_NUM; f++) begin
            // next code stalls through each scan
            for (int p = 0; p < PIXEL_NUM; p++) begin
                kind = pixelKind(f, p);
                r = nextRand();
                peak = r[21:16];
                for (int i = 0; i < ACQ_NUM; i++) begin
                    code = makeCode(kind, peak);
                    codeLog[p][i] = code;
                    sendCode(code);
                end
            end
            // log stays intact until the frame is checked
            wait (framesChecked == f + 1);
        end
    end

    initial begin : resultCheck
        logic [WB_DW-1:0] rd;
        logic [WB_DW-1:0] expWord;
        int expTotal;
        int actTotal;
        int kind;
        string name;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        wait (arstN === 1'b1);
        for (int f = 0; f < FRAME_NUM; f++) begin
            // poll status until frameDone
            rd = '0;
            while (!rd[0]) begin
                repeat (8) @(posedge clk);
                busCycle(1'b0, STATUS_ADR, '0, rd);
            end
            expTotal = 0;
            actTotal = 0;
            for (int p = 0; p < PIXEL_NUM; p++) begin
                kind = pixelKind(f, p);
                name = $sformatf("frame %0d pixel %0d %s", f, p, kindName(kind));
                expWord = {2'b00, refPeak(p)};
                busCycle(1'b0, WB_AW'(p), '0, rd);
                if (rd !== expWord) begin
                    reportError(name, expWord, rd);
                end
                // all burst codes must land in one bin
                if (kind == KIND_BURST && rd[7:0] !== peakMax'(ACQ_NUM)) begin
                    reportError(name, WB_DW'(ACQ_NUM), {8'd0, rd[7:0]});
                end
                endTest(name);
                expTotal += int'(expWord[7:0]);
                actTotal += int'(rd[7:0]);
            end
            // held codes counted once each
            name = $sformatf("frame %0d total", f);
            if (actTotal != expTotal) begin
                reportError(name, WB_DW'(expTotal), WB_DW'(actTotal));
            end
            endTest(name);
            name = $sformatf("frame %0d status set", f);
            expWord = {FRAME_W'(f + 1), 7'd0, 1'b1};
            busCycle(1'b0, STATUS_ADR, '0, rd);
            if (rd !== expWord) begin
                reportError(name, expWord, rd);
            end
            endTest(name);
            // bit 0 write clears the flag and keeps the counter
            name = $sformatf("frame %0d status clear", f);
            busCycle(1'b1, STATUS_ADR, 16'h0001, rd);
            busCycle(1'b0, STATUS_ADR, '0, rd);
            expWord = {FRAME_W'(f + 1), 8'd0};
            if (rd !== expWord) begin
                reportError(name, expWord, rd);
            end
            endTest(name);
            framesChecked = f + 1;
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: frames not finished after %0d cycles", cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/sifhTop_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module sifhTopAssert (
    input logic                clk,
    input logic                arstN,
    input logic                dataValid,
    input logic                dataReady,
    input sifhPkg::tdcCode_t   data,
    input logic                wbCyc,
    input logic                wbStb,
    input logic                wbAck
);

    // ack only inside an open strobe
    ackUnderStrobe: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |-> (wbCyc && wbStb))
        else $error("wbAck high without wbCyc and wbStb");

    // rise answers the request of the cycle before
    ackAfterRequest: assert property (@(posedge clk) disable iff (!arstN)
        $rose(wbAck) |-> $past(wbCyc && wbStb))
        else $error("wbAck rose without a request");

    ackOneCycle: assert property (@(posedge clk) disable iff (!arstN)
        wbAck |=> !wbAck)
        else $error("wbAck longer than one cycle");

    // stalled code must not move
    dataHeld: assert property (@(posedge clk) disable iff (!arstN)
        (dataValid && !dataReady) |=> $stable(data.raw))
        else $error("data changed while stalled");

endmodule

bind sifhTop sifhTopAssert u_sifhTopAssert (
    .clk       (clk),
    .arstN     (arstN),
    .dataValid (dataValid),
    .dataReady (dataReady),
    .data      (data),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbAck     (wbAck)
);

`default_nettype wire
